/* Bender.yml */
package:
  name: pxl_filter

sources:
  - hdl/pxl_filter_pkg.sv
  - hdl/pixel_ram.sv
  - hdl/apb_reg_decode.sv
  - hdl/frame_scan_filter.sv
  - hdl/pxl_filter_top.sv
  - target: test
    files:
      - testbench/tb_pxl_filter.sv

/* hdl/apb_reg_decode.sv */
// caution: rst is the clock, clk the async active-high reset; word addressed apb, no pstrb
module apb_reg_decode #(
  parameter int IMG_COLS = 80,
  parameter int IMG_ROWS = 60,
  localparam int N_PXL   = IMG_COLS * IMG_ROWS,
  localparam int ADDR_W  = $clog2(N_PXL)
) (
  input  logic                          rst,
  input  logic                          clk,
  input  pxl_filter_pkg::apb_req_t      apb_req,
  output pxl_filter_pkg::apb_rsp_t      apb_rsp,
  input  logic                          busy,         // frame pass running
  output logic                          start,        // one cycle pulse
  output pxl_filter_pkg::filter_mode_t  filter_mode,
  output pxl_filter_pkg::pxl_wr_t       src_wr,
  output logic [ADDR_W-1:0]             host_rd_addr, // shared by both windows
  input  pxl_filter_pkg::pxl_word_u     src_rd_pxl,
  input  pxl_filter_pkg::pxl_word_u     res_rd_pxl
);

  localparam int AW_MAX = pxl_filter_pkg::PXL_ADDR_MAX;

  logic              access;    // psel and penable
  logic [1:0]        region;
  logic [AW_MAX-1:0] offset;
  logic              in_reg, in_src, in_res;
  logic              out_of_range;
  logic              err;
  logic              win_rd;    // window read, needs the wait state
  logic              wait_done; // second access cycle of a window read
  logic              pready;
  logic              wr_ok;     // write that takes effect this cycle
  logic [31:0]       rdata;

  assign access = apb_req.psel && apb_req.penable;
  assign region = apb_req.paddr[pxl_filter_pkg::PADDR_W-1 -: 2];
  assign offset = apb_req.paddr[AW_MAX-1:0];
  assign in_reg = (region == pxl_filter_pkg::REG_REGION);
  assign in_src = (region == pxl_filter_pkg::SRC_REGION);
  assign in_res = (region == pxl_filter_pkg::RES_REGION);
  assign out_of_range = ({19'b0, offset} >= N_PXL);

  // error rules, state left untouched on any of these
  always_comb begin
    case (region)
      pxl_filter_pkg::REG_REGION:
        err = apb_req.pwrite && busy &&
              (offset == pxl_filter_pkg::CTRL_ADDR || offset == pxl_filter_pkg::FILT_ADDR);
      pxl_filter_pkg::SRC_REGION: err = out_of_range || (apb_req.pwrite && busy);
      pxl_filter_pkg::RES_REGION: err = out_of_range || apb_req.pwrite; // read only window
      default:                    err = 1'b1; // region 11 unused
    endcase
  end

  assign win_rd = !apb_req.pwrite && (in_src || in_res) && !err;
  assign pready = access && (!win_rd || wait_done); // regs and errors finish at once
  assign wr_ok  = pready && apb_req.pwrite && !err;

  // ram read issued from the address, data valid one cycle on
  assign host_rd_addr = offset[ADDR_W-1:0];

  always_comb begin
    src_wr         = '0;
    src_wr.we      = wr_ok && in_src; // lands in the first access cycle
    src_wr.addr    = offset;
    src_wr.pxl.raw = apb_req.pwdata[pxl_filter_pkg::NB_PXL-1:0];
  end

  always_comb begin
    rdata = '0;
    if (in_reg && offset == pxl_filter_pkg::FILT_ADDR) rdata[2:0] = filter_mode;
    if (in_reg && offset == pxl_filter_pkg::STAT_ADDR) rdata[3:0] = {filter_mode, busy};
    if (in_src) rdata[pxl_filter_pkg::NB_PXL-1:0] = src_rd_pxl.raw;
    if (in_res) rdata[pxl_filter_pkg::NB_PXL-1:0] = res_rd_pxl.raw; // unstable while busy
  end

  assign apb_rsp.prdata  = rdata;
  assign apb_rsp.pready  = pready;
  assign apb_rsp.pslverr = pready && err;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      wait_done   <= 1'b0;
      start       <= 1'b0;
      filter_mode <= pxl_filter_pkg::FILT_NONE;
    end else begin
      wait_done <= access && win_rd && !wait_done;
      // err already blocks ctrl while busy
      start <= wr_ok && in_reg && offset == pxl_filter_pkg::CTRL_ADDR && apb_req.pwdata[0];
      if (wr_ok && in_reg && offset == pxl_filter_pkg::FILT_ADDR) begin
        filter_mode <= pxl_filter_pkg::filter_mode_t'(apb_req.pwdata[2:0]);
      end else if (wr_ok && in_reg && offset == pxl_filter_pkg::CTRL_ADDR &&
                   apb_req.pwdata[1]) begin
        filter_mode <= pxl_filter_pkg::next_filter(filter_mode); // step the sequence
      end
    end
  end

  // completion only after a setup cycle, window reads one access cycle later
  a_pready_in_access: assert property (@(posedge rst) disable iff (clk)
    apb_rsp.pready |-> $past(apb_req.psel) && (!win_rd || $past(access)));

  a_no_start_busy: assert property (@(posedge rst) disable iff (clk)
    $rose(start) |-> !busy);

endmodule

/* hdl/frame_scan_filter.sv */
// caution: rst is the clock, clk the async active-high reset; one pass of N+2 cycles per start
module frame_scan_filter #(
  parameter int IMG_COLS = 80,
  parameter int IMG_ROWS = 60,
  localparam int N_PXL   = IMG_COLS * IMG_ROWS,
  localparam int ADDR_W  = $clog2(N_PXL)
) (
  input  logic                          rst,
  input  logic                          clk,
  input  logic                          start,
  input  pxl_filter_pkg::filter_mode_t  filter_mode, // held stable by the decoder
  output logic                          busy,
  output logic [ADDR_W-1:0]             scan_addr,   // source read address
  input  pxl_filter_pkg::pxl_word_u     src_pxl,     // one cycle behind scan_addr
  output pxl_filter_pkg::pxl_wr_t       res_wr
);

  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(N_PXL - 1);

  logic              rd_run;  // read phase, cycles 1..N
  logic [ADDR_W-1:0] rd_addr;
  logic              wr_run;  // write phase, one behind
  logic [ADDR_W-1:0] wr_addr; // rd_addr delayed for ram latency
  logic              last_rd;
  logic [2:0]        chan_msb;
  logic              keep;

  assign last_rd   = (rd_addr == LAST_ADDR);
  assign scan_addr = rd_addr;
  assign busy      = rd_run || wr_run; // high from cycle 1 through the last write

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rd_run  <= 1'b0;
      rd_addr <= '0;
      wr_run  <= 1'b0;
      wr_addr <= '0;
    end else begin
      wr_run  <= rd_run;
      wr_addr <= rd_addr;
      if (start && !busy) begin
        rd_run  <= 1'b1; // address 0 goes out next cycle
        rd_addr <= '0;
      end else if (rd_run) begin
        if (last_rd) begin
          rd_run  <= 1'b0;
          rd_addr <= '0;
        end else begin
          rd_addr <= rd_addr + 1'b1;
        end
      end
    end
  end

  // top bit of each channel, same r g b order as the mode
  assign chan_msb = {src_pxl.rgb.red[pxl_filter_pkg::NB_RED-1],
                     src_pxl.rgb.green[pxl_filter_pkg::NB_GREEN-1],
                     src_pxl.rgb.blue[pxl_filter_pkg::NB_BLUE-1]};

  // unselected channels count as set, so FILT_NONE keeps everything
  assign keep = &(chan_msb | ~filter_mode);

  always_comb begin
    res_wr                  = '0;
    res_wr.we               = wr_run;
    res_wr.addr[ADDR_W-1:0] = wr_addr;
    res_wr.pxl              = keep ? src_pxl : '0; // black when rejected
  end

  a_wr_addr_range: assert property (@(posedge rst) disable iff (clk)
    res_wr.we |-> ({19'b0, res_wr.addr} < N_PXL));

  // writes stay inside a pass and never overlap a new start
  a_wr_in_busy: assert property (@(posedge rst) disable iff (clk)
    res_wr.we |-> busy && !start);

endmodule

/* hdl/pixel_ram.sv */
// caution: rst is the clock, clk the async active-high reset; contents not cleared by reset
module pixel_ram #(
  parameter int IMG_COLS = 80,
  parameter int IMG_ROWS = 60,
  localparam int N_PXL   = IMG_COLS * IMG_ROWS,
  localparam int ADDR_W  = $clog2(N_PXL)
) (
  input  logic                       rst,
  input  logic                       clk,
  input  pxl_filter_pkg::pxl_wr_t    wr,
  input  logic [ADDR_W-1:0]          rd_addr,
  output pxl_filter_pkg::pxl_word_u  rd_pxl   // registered, one cycle after rd_addr
);

  logic [pxl_filter_pkg::NB_PXL-1:0] mem [N_PXL];

  // one write port, one read port, old data on same-address collision
  always_ff @(posedge rst) begin
    if (wr.we) begin
      mem[wr.addr[ADDR_W-1:0]] <= wr.pxl.raw; // only the low bits address the frame
    end
    rd_pxl.raw <= mem[rd_addr];
  end

  // both writers, decoder and filter, must stay inside the frame
  a_wr_in_frame: assert property (@(posedge rst) disable iff (clk)
    wr.we |-> ({19'b0, wr.addr} < N_PXL));

endmodule

/* hdl/pxl_filter_pkg.sv */
// caution: rst is the clock and clk the async active-high reset everywhere; pixel count < 8192
package pxl_filter_pkg;

  // colour channel widths, 4:4:4 rgb
  localparam int NB_RED   = 4;
  localparam int NB_GREEN = 4;
  localparam int NB_BLUE  = 4;
  localparam int NB_PXL   = NB_RED + NB_GREEN + NB_BLUE; // 12 bit pixel word

  // widest pixel address carried in a write port, enough for 80x60
  localparam int PXL_ADDR_MAX = 13;

  // apb side, word addressed
  localparam int PADDR_W = 15;
  localparam int PDATA_W = 32;

  // region lives in paddr[14:13], offset in paddr[12:0]
  localparam logic [1:0] REG_REGION = 2'b00;
  localparam logic [1:0] SRC_REGION = 2'b01; // source frame window
  localparam logic [1:0] RES_REGION = 2'b10; // result frame window, read only

  localparam logic [PXL_ADDR_MAX-1:0] CTRL_ADDR = 13'd0; // wo, bit0 start, bit1 next filter
  localparam logic [PXL_ADDR_MAX-1:0] FILT_ADDR = 13'd1; // rw, mode in bits 2:0
  localparam logic [PXL_ADDR_MAX-1:0] STAT_ADDR = 13'd2; // ro, bit0 busy, bits 3:1 mode

  typedef struct packed {
    logic [NB_RED-1:0]   red;   // top bits
    logic [NB_GREEN-1:0] green;
    logic [NB_BLUE-1:0]  blue;
  } pxl_rgb_t;

  // storage sees raw, filter sees colour fields
  typedef union packed {
    logic [NB_PXL-1:0] raw;
    pxl_rgb_t          rgb;
  } pxl_word_u;

  // one bit per kept channel, r g b from msb down
  typedef enum logic [2:0] {
    FILT_NONE = 3'b000, // pass-through
    FILT_R    = 3'b100,
    FILT_G    = 3'b010,
    FILT_B    = 3'b001,
    FILT_RG   = 3'b110,
    FILT_RB   = 3'b101,
    FILT_GB   = 3'b011,
    FILT_RGB  = 3'b111
  } filter_mode_t;

  typedef struct packed {
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [PADDR_W-1:0] paddr;
    logic [PDATA_W-1:0] pwdata;
  } apb_req_t; // 50 bits

  typedef struct packed {
    logic [PDATA_W-1:0] prdata;
    logic               pready;
    logic               pslverr;
  } apb_rsp_t; // 34 bits

  typedef struct packed {
    logic                    we;
    logic [PXL_ADDR_MAX-1:0] addr; // upper bits zero for small frames
    pxl_word_u               pxl;
  } pxl_wr_t;

  // fixed step order of the next filter command
  function automatic filter_mode_t next_filter(filter_mode_t mode);
    case (mode)
      FILT_NONE: return FILT_R;
      FILT_R:    return FILT_G;
      FILT_G:    return FILT_B;
      FILT_B:    return FILT_RG;
      FILT_RG:   return FILT_RB;
      FILT_RB:   return FILT_GB;
      FILT_GB:   return FILT_RGB;
      default:   return FILT_NONE; // rgb wraps round
    endcase
  endfunction

endpackage

/* hdl/pxl_filter_top.sv */
// caution: rst is the clock, clk the async active-high reset; apb is the only interface
module pxl_filter_top #(
  parameter int IMG_COLS = 80, // frame width in pixels
  parameter int IMG_ROWS = 60, // frame height, cols*rows < 8192
  localparam int N_PXL   = IMG_COLS * IMG_ROWS,
  localparam int ADDR_W  = $clog2(N_PXL)
) (
  input  logic                      rst,
  input  logic                      clk,
  input  pxl_filter_pkg::apb_req_t  apb_req,
  output pxl_filter_pkg::apb_rsp_t  apb_rsp
);

  logic                         start;
  logic                         busy;
  pxl_filter_pkg::filter_mode_t filter_mode;
  pxl_filter_pkg::pxl_wr_t      src_wr;       // host writes the original image
  pxl_filter_pkg::pxl_wr_t      res_wr;       // filter writes the result
  logic [ADDR_W-1:0]            host_rd_addr;
  logic [ADDR_W-1:0]            scan_addr;
  logic [ADDR_W-1:0]            src_rd_addr;
  pxl_filter_pkg::pxl_word_u    src_rd_pxl;
  pxl_filter_pkg::pxl_word_u    res_rd_pxl;

  // filter owns the source read port during a pass
  assign src_rd_addr = busy ? scan_addr : host_rd_addr;

  apb_reg_decode #(.IMG_COLS(IMG_COLS), .IMG_ROWS(IMG_ROWS)) u_decode (
    .rst          (rst),
    .clk          (clk),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .busy         (busy),
    .start        (start),
    .filter_mode  (filter_mode),
    .src_wr       (src_wr),
    .host_rd_addr (host_rd_addr),
    .src_rd_pxl   (src_rd_pxl),
    .res_rd_pxl   (res_rd_pxl)
  );

  frame_scan_filter #(.IMG_COLS(IMG_COLS), .IMG_ROWS(IMG_ROWS)) u_execute (
    .rst         (rst),
    .clk         (clk),
    .start       (start),
    .filter_mode (filter_mode),
    .busy        (busy),
    .scan_addr   (scan_addr),
    .src_pxl     (src_rd_pxl),
    .res_wr      (res_wr)
  );

  pixel_ram #(.IMG_COLS(IMG_COLS), .IMG_ROWS(IMG_ROWS)) src_ram (
    .rst     (rst),
    .clk     (clk),
    .wr      (src_wr),
    .rd_addr (src_rd_addr),
    .rd_pxl  (src_rd_pxl)
  );

  // result frame, read back by the host only
  pixel_ram #(.IMG_COLS(IMG_COLS), .IMG_ROWS(IMG_ROWS)) res_ram (
    .rst     (rst),
    .clk     (clk),
    .wr      (res_wr),
    .rd_addr (host_rd_addr),
    .rd_pxl  (res_rd_pxl)
  );

endmodule

/* pxl_filter_top.f */
hdl/pxl_filter_pkg.sv
hdl/pixel_ram.sv
hdl/apb_reg_decode.sv
hdl/frame_scan_filter.sv
hdl/pxl_filter_top.sv
testbench/tb_pxl_filter.sv

/* testbench/tb_pxl_filter.sv */
// caution: rst is the clock, clk the async active-high reset; 16x8 frame, first mismatch stops the run
module tb_pxl_filter;

  localparam int IMG_COLS = 16;
  localparam int IMG_ROWS = 8;
  localparam int N_PXL    = IMG_COLS * IMG_ROWS; // 128 pixels
  localparam int RST_CYC  = 16;
  localparam int WR_CYC   = 4;                   // setup, access, release, idle
  localparam int RD_CYC   = 5;                   // plus one wait state on windows
  localparam int PASS_CYC = N_PXL + 2;
  // five passes, image load, 4 readbacks, doubled, plus register traffic
  localparam int TIMEOUT_CYC =
    2 * (RST_CYC + 5 * PASS_CYC + N_PXL * WR_CYC + 4 * N_PXL * RD_CYC) + 1000;

  // address map, region in the top two bits
  localparam logic [1:0] R_REG = 2'b00;
  localparam logic [1:0] R_SRC = 2'b01;
  localparam logic [1:0] R_RES = 2'b10;
  localparam logic [1:0] R_BAD = 2'b11; // unused region
  localparam int CTRL_OFS = 0;
  localparam int FILT_OFS = 1;
  localparam int STAT_OFS = 2;

  // none, r, g, b, rg, rb, gb, rgb, from the left
  localparam logic [23:0] STEP_ORDER =
    {3'b000, 3'b100, 3'b010, 3'b001, 3'b110, 3'b101, 3'b011, 3'b111};

  logic                     rst;     // clock
  logic                     clk;     // reset, active high
  pxl_filter_pkg::apb_req_t apb_req;
  pxl_filter_pkg::apb_rsp_t apb_rsp;

  logic [11:0] src_img [N_PXL];      // host copy of the source frame
  int unsigned cycles;

  pxl_filter_top #(.IMG_COLS(IMG_COLS), .IMG_ROWS(IMG_ROWS)) UUT (
    .rst     (rst),
    .clk     (clk),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  always #50 rst = ~rst; // period 100

  // run limit
  always @(posedge rst) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYC) begin
      $display("timeout after %0d cycles, the DUT stopped answering or never went idle", cycles);
      $display("TEST FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  function automatic logic [14:0] addr_of(input logic [1:0] region, input int offset);
    return {region, 13'(offset)};
  endfunction

  // expected pixel: every selected channel needs its top bit set, else black
  function automatic logic [11:0] ref_filter(input logic [11:0] pxl, input logic [2:0] mode);
    logic red_ok;
    logic green_ok;
    logic blue_ok;
    red_ok   = !mode[2] || pxl[11];
    green_ok = !mode[1] || pxl[7];
    blue_ok  = !mode[0] || pxl[3];
    return (red_ok && green_ok && blue_ok) ? pxl : 12'h000;
  endfunction

  // successor in the step order table
  function automatic logic [2:0] next_mode(input logic [2:0] mode);
    int k;
    for (k = 0; k < 8; k++) begin
      if (STEP_ORDER[23-3*k -: 3] == mode) return STEP_ORDER[23-3*((k+1)%8) -: 3];
    end
    return 3'b000;
  endfunction

  task automatic compare_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // one apb transfer, driven on rising edges, sampled on falling edges
  task automatic bus_xfer(input logic wr, input logic [14:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic slverr, output int waits);
    waits = 0;
    @(posedge rst);
    apb_req.psel    <= 1'b1; // setup cycle
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge rst);
    apb_req.penable <= 1'b1; // access cycle
    @(negedge rst);
    while (!apb_rsp.pready) begin // window reads stall one cycle
      waits++;
      @(negedge rst);
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge rst);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic write_word(input logic [14:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] unused;
    logic        slverr;
    int          waits;
    bus_xfer(1'b1, addr, data, unused, slverr, waits);
    compare_val($sformatf("pslverr wr %h", addr), slverr, exp_err);
    compare_val($sformatf("pready waits wr %h", addr), waits, 0); // writes never stall
  endtask

  task automatic read_word(input logic [14:0] addr, output logic [31:0] data,
                           input logic exp_err);
    logic slverr;
    int   waits;
    int   exp_waits;
    bus_xfer(1'b0, addr, 32'h0, data, slverr, waits);
    compare_val($sformatf("pslverr rd %h", addr), slverr, exp_err);
    // good window reads take one wait state for the registered ram
    exp_waits = (!exp_err && (addr[14:13] == R_SRC || addr[14:13] == R_RES)) ? 1 : 0;
    compare_val($sformatf("pready waits rd %h", addr), waits, exp_waits);
  endtask

  // poll STAT until busy drops
  task automatic wait_idle();
    logic [31:0] stat;
    stat = 32'h1;
    while (stat[0]) read_word(addr_of(R_REG, STAT_OFS), stat, 1'b0);
  endtask

  // load mode, start, wait, read back and compare the whole result frame
  task automatic run_pass(input logic [2:0] mode);
    logic [31:0] rd;
    int          i;
    write_word(addr_of(R_REG, FILT_OFS), {29'b0, mode}, 1'b0);
    read_word(addr_of(R_REG, FILT_OFS), rd, 1'b0);
    compare_val("filter_mode", rd, {29'b0, mode});
    write_word(addr_of(R_REG, CTRL_OFS), 32'h1, 1'b0); // start bit
    wait_idle();
    for (i = 0; i < N_PXL; i++) begin
      read_word(addr_of(R_RES, i), rd, 1'b0);
      compare_val($sformatf("res_pxl[%0d]", i), rd, {20'b0, ref_filter(src_img[i], mode)});
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic [2:0]  mode;
    int          i;
    rst     = 1'b0;
    clk     = 1'b1; // reset held from time 0
    apb_req = '0;
    cycles  = 0;
    void'($urandom(32'h95f00e97)); // seed once
    repeat (RST_CYC) @(posedge rst);
    clk <= 1'b0;

    // idle, mode none
    read_word(addr_of(R_REG, STAT_OFS), rd, 1'b0);
    compare_val("stat after reset", rd, 32'h0);

    // eight next commands walk the whole order and wrap
    mode = 3'b000;
    for (i = 0; i < 8; i++) begin
      write_word(addr_of(R_REG, CTRL_OFS), 32'h2, 1'b0);
      mode = next_mode(mode);
      read_word(addr_of(R_REG, STAT_OFS), rd, 1'b0);
      compare_val($sformatf("stat step %0d", i), rd, {28'b0, mode, 1'b0});
    end

    for (i = 0; i < N_PXL; i++) begin
      src_img[i] = 12'($urandom());
      write_word(addr_of(R_SRC, i), {20'b0, src_img[i]}, 1'b0);
    end

    run_pass(3'b000); // pass-through
    run_pass(3'b100); // red
    run_pass(3'b011); // green and blue
    run_pass(3'b111); // all three

    // rejected writes during a pass
    write_word(addr_of(R_REG, CTRL_OFS), 32'h1, 1'b0);
    read_word(addr_of(R_REG, STAT_OFS), rd, 1'b0);
    compare_val("busy", rd[0], 1'b1);
    write_word(addr_of(R_REG, FILT_OFS), 32'h2, 1'b1);
    write_word(addr_of(R_REG, CTRL_OFS), 32'h3, 1'b1);
    write_word(addr_of(R_SRC, 5), {20'b0, ~src_img[5]}, 1'b1);
    write_word(addr_of(R_SRC, 0), {20'b0, ~src_img[0]}, 1'b1);
    wait_idle();
    read_word(addr_of(R_REG, FILT_OFS), rd, 1'b0);
    compare_val("filter_mode after busy", rd, 32'h7);
    read_word(addr_of(R_SRC, 5), rd, 1'b0);
    compare_val("src_pxl[5]", rd, {20'b0, src_img[5]});
    read_word(addr_of(R_SRC, 0), rd, 1'b0);
    compare_val("src_pxl[0]", rd, {20'b0, src_img[0]});

    // illegal windows and regions
    write_word(addr_of(R_RES, 0), 32'hfff, 1'b1);
    read_word(addr_of(R_BAD, 0), rd, 1'b1);
    write_word(addr_of(R_BAD, 1), 32'h1, 1'b1);
    read_word(addr_of(R_SRC, N_PXL), rd, 1'b1);
    write_word(addr_of(R_SRC, N_PXL), 32'h5a5, 1'b1);
    read_word(addr_of(R_RES, N_PXL), rd, 1'b1);
    read_word(addr_of(R_RES, 4000), rd, 1'b1);
    read_word(addr_of(R_RES, 0), rd, 1'b0); // result untouched by the bad write
    compare_val("res_pxl[0] kept", rd, {20'b0, ref_filter(src_img[0], 3'b111)});

    $display("TEST PASS");
    $finish;
  end

endmodule
